//--- hdl/rsaPkg.sv
// ##############################
// rsa operand package
// word and operand widths and the
// data types built on them
// ##############################

package rsaPkg;

   localparam int WordBits    = 32;                   // host bus width
   localparam int NumWords    = 4;                    // words per operand
   localparam int OperandBits = WordBits * NumWords;  // 128 bit operands

   // one host word
   typedef logic [WordBits-1:0] word_t;

   // a full operand (key, modulus, message, result)
   typedef logic [OperandBits-1:0] operand_t;

   // word index within a burst
   typedef logic [$clog2(NumWords)-1:0] wordCount_t;

   // bit index within an operand
   typedef logic [$clog2(OperandBits)-1:0] bitCount_t;

endpackage

//--- hdl/rsaCtrlPkg.sv
// ##############################
// rsa control package
// host state codes and the
// burst target select
// ##############################

package rsaCtrlPkg;

   // state codes as seen on the state output
   typedef enum logic [2:0] {
      INIT     = 3'd1,
      IDLE     = 3'd2,
      KEY_GET  = 3'd3,
      MOD_GET  = 3'd4,
      DATA_GET = 3'd5,
      DATA_OUT = 3'd6,
      ENCRYPT  = 3'd7
   } hostState_t;

   typedef enum logic [1:0] {
      SelKey,
      SelMod,
      SelData
   } operandSel_t;

endpackage

//--- hdl/mulIf.sv
// ##############################
// modular multiply interface
// exponent sequencer to multiplier
// ##############################

`timescale 1ns/100ps

interface mulIf import rsaPkg::*; ();

   logic     start;         // one cycle, operands sampled here
   operand_t multiplicand;
   operand_t multiplier;
   operand_t modulus;
   operand_t product;       // valid from done until next start
   logic     done;          // one cycle pulse

   modport master (output start, multiplicand, multiplier, modulus,
                   input  product, done);

   modport slave  (input  start, multiplicand, multiplier, modulus,
                   output product, done);

endinterface

//--- hdl/hostSequencer.sv
// ##############################
// host command decoder
// load, encrypt and output FSM
// ##############################

`timescale 1ns/100ps

module hostSequencer import rsaPkg::*, rsaCtrlPkg::*; (
   input  logic        CLK,
   input  logic        resetn,
   input  logic        enable,
   input  logic        keyReady,
   input  logic        modReady,
   input  logic        dataReady,
   input  logic        expDone,
   output hostState_t  state,
   output logic        finish,
   output logic        keyEnd,
   output logic        modEnd,
   output logic        dataOutReady,
   output logic        loadWord,
   output operandSel_t loadSel,
   output logic        expStart,
   output logic        outShift
);

   wordCount_t wordCnt;
   logic       keyLoaded, modLoaded;   // loaded since reset
   logic       resultPending;          // expDone seen while frozen
   logic       lastWord;
   logic       inBurst;

   assign lastWord = (wordCnt == wordCount_t'(NumWords - 1));
   assign inBurst  = (state == KEY_GET) || (state == MOD_GET) || (state == DATA_GET);
   assign loadWord = enable && inBurst;
   assign outShift = enable && (state == DATA_OUT);
   assign finish   = (state != INIT) && (state != IDLE);

   always_comb begin
      case (state)
         KEY_GET: loadSel = SelKey;
         MOD_GET: loadSel = SelMod;
         default: loadSel = SelData;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (!resetn) begin
         state         <= INIT;
         wordCnt       <= '0;
         keyLoaded     <= 1'b0;
         modLoaded     <= 1'b0;
         keyEnd        <= 1'b0;
         modEnd        <= 1'b0;
         dataOutReady  <= 1'b0;
         expStart      <= 1'b0;
         resultPending <= 1'b0;
      end else begin
         dataOutReady <= 1'b0;             // single cycle pulses
         expStart     <= 1'b0;
         if (expDone)
            resultPending <= 1'b1;
         if (enable) begin
            case (state)
               INIT, IDLE: begin
                  wordCnt <= '0;
                  if (keyReady || modReady ||
                      (dataReady && state == IDLE && keyLoaded && modLoaded)) begin
                     keyEnd <= 1'b0;       // new command clears both end flags
                     modEnd <= 1'b0;
                  end
                  if (keyReady)
                     state <= KEY_GET;
                  else if (modReady)
                     state <= MOD_GET;
                  else if (dataReady && state == IDLE && keyLoaded && modLoaded)
                     state <= DATA_GET;
               end
               KEY_GET: begin
                  wordCnt <= wordCnt + 1'b1;
                  if (lastWord) begin
                     state     <= IDLE;
                     keyEnd    <= 1'b1;
                     keyLoaded <= 1'b1;
                  end
               end
               MOD_GET: begin
                  wordCnt <= wordCnt + 1'b1;
                  if (lastWord) begin
                     state     <= IDLE;
                     modEnd    <= 1'b1;
                     modLoaded <= 1'b1;
                  end
               end
               DATA_GET: begin
                  wordCnt <= wordCnt + 1'b1;
                  if (lastWord) begin
                     state    <= ENCRYPT;
                     expStart <= 1'b1;     // message complete from next cycle
                  end
               end
               ENCRYPT: begin
                  if (expDone || resultPending) begin
                     state         <= DATA_OUT;
                     dataOutReady  <= 1'b1;
                     wordCnt       <= '0;
                     resultPending <= 1'b0;
                  end
               end
               DATA_OUT: begin
                  wordCnt <= wordCnt + 1'b1;
                  if (lastWord)
                     state <= IDLE;
               end
               default: state <= IDLE;
            endcase
         end
      end
   end

endmodule

//--- hdl/operandStore.sv
// ##############################
// operand load registers
// word serial key, modulus and
// message with key bit rotation
// ##############################

`timescale 1ns/100ps

module operandStore import rsaPkg::*, rsaCtrlPkg::*; (
   input  logic        CLK,
   input  logic        resetn,
   input  word_t       keyIn,
   input  word_t       modIn,
   input  word_t       dataIn,
   input  logic        loadWord,
   input  operandSel_t loadSel,
   input  logic        keyShift,
   output logic        keyMsb,
   output operand_t    modulus,
   output operand_t    message
);

   operand_t key;

   always_ff @(posedge CLK) begin
      if (!resetn)
         key <= '0;
      else if (loadWord && loadSel == SelKey)
         key <= {keyIn, key[OperandBits-1:WordBits]};    // first word ends lowest
      else if (keyShift)
         key <= {key[OperandBits-2:0], key[OperandBits-1]};   // rotate, msb first
   end

   always_ff @(posedge CLK) begin
      if (loadWord && loadSel == SelMod)
         modulus <= {modIn, modulus[OperandBits-1:WordBits]};
      if (loadWord && loadSel == SelData)
         message <= {dataIn, message[OperandBits-1:WordBits]};
   end

   assign keyMsb = key[OperandBits-1];

endmodule

//--- hdl/expSequencer.sv
// ##############################
// binary exponentiation control
// left to right square and multiply
// ##############################

`timescale 1ns/100ps

module expSequencer import rsaPkg::*; (
   input  logic       CLK,
   input  logic       resetn,
   input  logic       expStart,
   input  logic       keyMsb,
   input  operand_t   modulus,
   input  operand_t   message,
   output logic       keyShift,
   output logic       expDone,
   output operand_t   result,
   mulIf.master       mul
);

   typedef enum logic [1:0] {PhIdle, PhScan, PhSqr, PhMul} phase_t;

   phase_t    phase;
   bitCount_t bitCnt;      // key bits consumed, wraps after the last
   logic      started;     // first 1 bit found
   logic      curBit;      // key bit of the current step
   logic      mulMsg;      // second operand is the message
   operand_t  acc;

   assign keyShift         = (phase == PhScan);
   assign result           = acc;
   assign mul.multiplicand = acc;
   assign mul.multiplier   = mulMsg ? message : acc;
   assign mul.modulus      = modulus;

   always_ff @(posedge CLK) begin
      if (!resetn) begin
         phase     <= PhIdle;
         bitCnt    <= '0;
         started   <= 1'b0;
         mul.start <= 1'b0;
         expDone   <= 1'b0;
      end else begin
         mul.start <= 1'b0;
         expDone   <= 1'b0;
         case (phase)
            PhIdle: begin
               if (expStart) begin
                  phase   <= PhScan;
                  bitCnt  <= '0;
                  started <= 1'b0;
                  acc     <= operand_t'(1);   // all zero key gives 1
               end
            end
            PhScan: begin
               bitCnt <= bitCnt + 1'b1;
               curBit <= keyMsb;
               if (started) begin
                  mul.start <= 1'b1;          // square first
                  mulMsg    <= 1'b0;
                  phase     <= PhSqr;
               end else begin
                  if (keyMsb) begin
                     acc     <= message;
                     started <= 1'b1;
                  end
                  if (bitCnt == bitCount_t'(OperandBits - 1)) begin
                     expDone <= 1'b1;
                     phase   <= PhIdle;
                  end
               end
            end
            PhSqr: begin
               if (mul.done) begin
                  acc <= mul.product;
                  if (curBit) begin
                     mul.start <= 1'b1;
                     mulMsg    <= 1'b1;
                     phase     <= PhMul;
                  end else if (bitCnt == '0) begin
                     expDone <= 1'b1;
                     phase   <= PhIdle;
                  end else begin
                     phase <= PhScan;
                  end
               end
            end
            PhMul: begin
               if (mul.done) begin
                  acc   <= mul.product;
                  phase <= (bitCnt == '0) ? PhIdle : PhScan;
                  if (bitCnt == '0)
                     expDone <= 1'b1;
               end
            end
            default: phase <= PhIdle;
         endcase
      end
   end

endmodule

//--- hdl/modMultiplier.sv
// ##############################
// bit serial modular multiplier
// interleaved a * b mod n, one
// multiplier bit per cycle
// ##############################

`timescale 1ns/100ps

module modMultiplier import rsaPkg::*; (
   input  logic CLK,
   input  logic resetn,
   mulIf.slave  mul
);

   operand_t             a, b, n;
   logic [OperandBits:0] acc;              // one spare bit for 2 * acc
   logic [OperandBits:0] dbl, red1, sum, red2;
   logic [OperandBits:0] nExt;
   bitCount_t            cnt;
   logic                 busy;

   always_comb begin
      nExt = {1'b0, n};
      dbl  = acc << 1;
      red1 = (dbl >= nExt) ? dbl - nExt : dbl;          // first reduction
      sum  = red1 + (b[OperandBits-1] ? {1'b0, a} : '0);
      red2 = (sum >= nExt) ? sum - nExt : sum;          // second reduction
   end

   always_ff @(posedge CLK) begin
      if (!resetn) begin
         busy     <= 1'b0;
         cnt      <= '0;
         mul.done <= 1'b0;
      end else begin
         mul.done <= 1'b0;
         if (mul.start) begin
            a    <= mul.multiplicand;
            b    <= mul.multiplier;
            n    <= mul.modulus;
            acc  <= '0;
            cnt  <= '0;
            busy <= 1'b1;
         end else if (busy) begin
            acc <= red2;
            b   <= b << 1;
            cnt <= cnt + 1'b1;
            if (cnt == bitCount_t'(OperandBits - 1)) begin
               busy     <= 1'b0;
               mul.done <= 1'b1;
            end
         end
      end
   end

   assign mul.product = acc[OperandBits-1:0];

endmodule

//--- hdl/resultUnloader.sv
// ##############################
// result output shifter
// one word per cycle, lsw first
// ##############################

`timescale 1ns/100ps

module resultUnloader import rsaPkg::*; (
   input  logic     CLK,
   input  logic     resetn,
   input  logic     expDone,
   input  operand_t result,
   input  logic     outShift,
   output word_t    dataOut
);

   operand_t outReg;

   always_ff @(posedge CLK) begin
      if (!resetn)
         outReg <= '0;
      else if (expDone)
         outReg <= result;                 // capture final accumulator
      else if (outShift)
         outReg <= outReg >> WordBits;     // next word down
   end

   assign dataOut = outReg[WordBits-1:0];

endmodule

//--- hdl/rsaTop.sv
// ##############################
// rsa modexp macro top level
// computes data ** key mod mod
// over a 32 bit word serial host bus
// ##############################

`timescale 1ns/100ps

module rsaTop import rsaPkg::*, rsaCtrlPkg::*; (
   input  logic       CLK,
   input  logic       resetn,
   input  logic       enable,
   input  word_t      keyIn,
   input  word_t      modIn,
   input  word_t      dataIn,
   input  logic       keyReady,
   input  logic       modReady,
   input  logic       dataReady,
   output word_t      dataOut,
   output logic       finish,
   output logic       keyEnd,
   output logic       modEnd,
   output logic       dataOutReady,
   output hostState_t state
);

   logic        loadWord;
   operandSel_t loadSel;
   logic        expStart;
   logic        expDone;
   logic        outShift;
   logic        keyShift;
   logic        keyMsb;
   operand_t    modulus;
   operand_t    message;
   operand_t    result;

   mulIf mul_i ();

   // decode
   hostSequencer hostSeq_i (
      .CLK, .resetn, .enable, .keyReady, .modReady, .dataReady, .expDone,
      .state, .finish, .keyEnd, .modEnd, .dataOutReady,
      .loadWord, .loadSel, .expStart, .outShift
   );

   operandStore store_i (
      .CLK, .resetn, .keyIn, .modIn, .dataIn, .loadWord, .loadSel, .keyShift,
      .keyMsb, .modulus, .message
   );

   // execute
   expSequencer expSeq_i (
      .CLK, .resetn, .expStart, .keyMsb, .modulus, .message,
      .keyShift, .expDone, .result, .mul(mul_i.master)
   );

   modMultiplier modMul_i (
      .CLK, .resetn, .mul(mul_i.slave)
   );

   // result
   resultUnloader unload_i (
      .CLK, .resetn, .expDone, .result, .outShift, .dataOut
   );

endmodule

//--- verif/rsaTb_sva.sv
// ##############################
// rsa top control assertions
// host state, finish and output
// ready pulse rules
// ##############################

`timescale 1ns/100ps

module rsaSva import rsaCtrlPkg::*; (
   input logic       CLK,
   input logic       resetn,
   input hostState_t state,
   input logic       finish,
   input logic       dataOutReady
);

   finishMatchesState: assert property (@(posedge CLK) disable iff (!resetn)
      finish == (state != INIT && state != IDLE))
      else $error("finish disagrees with the host state");

   readySinglePulse: assert property (@(posedge CLK) disable iff (!resetn)
      dataOutReady |=> !dataOutReady)
      else $error("dataOutReady high on two consecutive cycles");

   // ready only rises together with entry to output
   readyInDataOut: assert property (@(posedge CLK) disable iff (!resetn)
      $rose(dataOutReady) |-> state == DATA_OUT)
      else $error("dataOutReady rose outside DATA_OUT");

   legalState: assert property (@(posedge CLK) disable iff (!resetn)
      state inside {INIT, IDLE, KEY_GET, MOD_GET, DATA_GET, DATA_OUT, ENCRYPT})
      else $error("host state holds an illegal code");

endmodule

bind rsaTop rsaSva sva_i (.CLK, .resetn, .state, .finish, .dataOutReady);

//--- verif/rsaTb.sv
// ##############################
// rsa modexp testbench
// table driven loads, encrypt and
// word serial readback vs a model
// ##############################

`timescale 1ns/100ps

module rsaTb import rsaPkg::*, rsaCtrlPkg::*; ();

   localparam int NumCases = 7;
   localparam int Timeout  = 100000;   // cycles allowed per encrypt

   typedef logic [2*OperandBits-1:0] wide_t;

   logic       CLK;
   logic       resetn;
   logic       enable;
   logic       keyReady;
   logic       modReady;
   logic       dataReady;
   word_t      keyIn;
   word_t      modIn;
   word_t      dataIn;
   word_t      dataOut;
   logic       finish;
   logic       keyEnd;
   logic       modEnd;
   logic       dataOutReady;
   hostState_t state;

   int          errorCount;
   int          timeoutCount;
   logic [31:0] lfsrState;

   string    caseName  [NumCases];
   logic     reloadTab [NumCases];   // load key and modulus first
   operand_t keyTab    [NumCases];
   operand_t modTab    [NumCases];
   operand_t dataTab   [NumCases];

   rsaTop dut_i (
      .CLK, .resetn, .enable, .keyIn, .modIn, .dataIn,
      .keyReady, .modReady, .dataReady,
      .dataOut, .finish, .keyEnd, .modEnd, .dataOutReady, .state
   );

   always #5 CLK = ~CLK;

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic drawOperand(output operand_t v);
      int i;
      v = '0;
      for (i = 0; i < OperandBits; i++) begin
         v = {v[OperandBits-2:0], lfsrState[0]};
         lfsrState = lfsrNext(lfsrState);   // one step per bit
      end
   endtask

   // square and multiply from the top key bit with double width products
   function automatic operand_t refModExp(input operand_t base, input operand_t expo,
                                          input operand_t m);
      wide_t r;
      wide_t b;
      wide_t mw;
      int    i;
      mw = wide_t'(m);
      b  = wide_t'(base) % mw;
      r  = wide_t'(1) % mw;
      for (i = OperandBits - 1; i >= 0; i--) begin
         r = (r * r) % mw;
         if (expo[i])
            r = (r * b) % mw;
      end
      return r[OperandBits-1:0];
   endfunction

   task automatic checkValue(input string name, input operand_t expected,
                             input operand_t actual);
      assert (actual === expected) else begin
         errorCount++;
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic buildTable();
      int       i;
      operand_t k;
      operand_t m;
      operand_t d;
      for (i = 0; i < NumCases; i++) begin
         drawOperand(k);
         drawOperand(m);
         drawOperand(d);
         reloadTab[i] = 1'b1;
         keyTab[i]    = k;
         modTab[i]    = m | operand_t'(2);      // modulus at least 2
         dataTab[i]   = d % modTab[i];
      end
      caseName[0] = "keyZero";
      caseName[1] = "keyOne";
      caseName[2] = "keyTop";
      caseName[3] = "random0";
      caseName[4] = "random1";
      caseName[5] = "keyReuse";
      caseName[6] = "smallMod";
      keyTab[0]    = '0;
      keyTab[1]    = operand_t'(1);
      keyTab[2]    = {1'b1, {(OperandBits-1){1'b0}}};
      reloadTab[5] = 1'b0;                      // key and modulus kept from random1
      keyTab[5]    = keyTab[4];
      modTab[5]    = modTab[4];
      dataTab[5]   = dataTab[5] % modTab[5];
      modTab[6]    = operand_t'(13);
      dataTab[6]   = dataTab[6] % modTab[6];
   endtask

   // strobe then one word per cycle from a falling edge
   task automatic sendBurst(input int target, input operand_t value, input string tag);
      int    w;
      word_t cur;
      case (target)
         0:       keyReady = 1'b1;
         1:       modReady = 1'b1;
         default: dataReady = 1'b1;
      endcase
      for (w = 0; w < NumWords; w++) begin
         @(negedge CLK);
         keyReady  = 1'b0;
         modReady  = 1'b0;
         dataReady = 1'b0;
         cur       = value[w*WordBits +: WordBits];
         keyIn     = (target == 0) ? cur : ~cur;   // other buses carry the complement
         modIn     = (target == 1) ? cur : ~cur;
         dataIn    = (target == 2) ? cur : ~cur;
         checkValue($sformatf("%s finish in burst", tag), operand_t'(1), operand_t'(finish));
      end
      @(negedge CLK);   // last word taken
   endtask

   initial begin
      int       c;
      int       n;
      int       k;
      operand_t got;
      operand_t expected;
      CLK          = 1'b0;
      resetn       = 1'b0;
      enable       = 1'b1;
      keyReady     = 1'b0;
      modReady     = 1'b0;
      dataReady    = 1'b0;
      keyIn        = '0;
      modIn        = '0;
      dataIn       = '0;
      errorCount   = 0;
      timeoutCount = 0;
      lfsrState    = 32'hdf6c;
      buildTable();
      repeat (10) @(negedge CLK);
      checkValue("reset state", operand_t'(INIT), operand_t'(state));
      checkValue("reset flags", '0, operand_t'({finish, keyEnd, modEnd, dataOutReady}));
      resetn    = 1'b1;
      dataReady = 1'b1;         // nothing loaded yet
      @(negedge CLK);
      dataReady = 1'b0;
      checkValue("early data strobe", operand_t'(INIT), operand_t'(state));
      enable   = 1'b0;
      keyReady = 1'b1;
      @(negedge CLK);
      keyReady = 1'b0;
      enable   = 1'b1;
      checkValue("strobe with enable low", operand_t'(INIT), operand_t'(state));
      for (c = 0; c < NumCases; c++) begin
         if (reloadTab[c]) begin
            sendBurst(0, keyTab[c], {caseName[c], " key"});
            checkValue({caseName[c], " keyEnd"}, operand_t'(1), operand_t'(keyEnd));
            checkValue({caseName[c], " key state"}, operand_t'(IDLE), operand_t'(state));
            if (c == 0) begin
               dataReady = 1'b1;       // modulus not loaded yet
               @(negedge CLK);
               dataReady = 1'b0;
               checkValue("data strobe before modulus", operand_t'(IDLE), operand_t'(state));
            end
            sendBurst(1, modTab[c], {caseName[c], " mod"});
            checkValue({caseName[c], " modEnd"}, operand_t'(1), operand_t'(modEnd));
            checkValue({caseName[c], " keyEnd drop"}, '0, operand_t'(keyEnd));
            checkValue({caseName[c], " mod state"}, operand_t'(IDLE), operand_t'(state));
         end
         sendBurst(2, dataTab[c], {caseName[c], " data"});
         checkValue({caseName[c], " encrypt state"}, operand_t'(ENCRYPT), operand_t'(state));
         n = 0;
         while (!dataOutReady && n < Timeout) begin
            @(negedge CLK);
            n++;
         end
         if (!dataOutReady) begin
            timeoutCount++;
            $display("timeout: no dataOutReady in case %s", caseName[c]);
            break;
         end
         for (k = 0; k < NumWords; k++) begin
            got[k*WordBits +: WordBits] = dataOut;
            @(negedge CLK);
         end
         expected = refModExp(dataTab[c], keyTab[c], modTab[c]);
         checkValue({caseName[c], " result"}, expected, got);
         checkValue({caseName[c], " final state"}, operand_t'(IDLE), operand_t'(state));
         checkValue({caseName[c], " final finish"}, '0, operand_t'(finish));
      end
      $display("errors: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
      if (errorCount == 0 && timeoutCount == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- compile.f
hdl/rsaPkg.sv
hdl/rsaCtrlPkg.sv
hdl/mulIf.sv
hdl/hostSequencer.sv
hdl/operandStore.sv
hdl/expSequencer.sv
hdl/modMultiplier.sv
hdl/resultUnloader.sv
hdl/rsaTop.sv
verif/rsaTb_sva.sv
verif/rsaTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rsa testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rsaTb -f compile.f -o rsaSim

simOut=$(./obj_dir/rsaSim) || true
echo "$simOut"

if grep -qF '*** PASSED ***' <<< "$simOut"; then
   exit 0
fi
exit 1
